/* rtl/sm_mem_pkg.sv */
////////////////////////////////////////
// busy data memory package
// sizes, delay setting, word types and
// the delay controller state encoding
////////////////////////////////////////

`default_nettype none

package sm_mem_pkg;

    // data path widths
    localparam int SM_DATA_W = 32;
    localparam int SM_ADDR_W = 32;   // byte address

    // word array geometry
    localparam int SM_RAM_SIZE   = 64;                   // depth in words
    localparam int SM_WORD_IDX_W = $clog2(SM_RAM_SIZE);  // 6 for 64 words

    // total cycles from accepting edge to response cycle, 2..255
    localparam int SM_DELAY = 4;

    // busy counter runs 0..SM_BUSY_LAST while in S_BUSY
    localparam logic [7:0] SM_BUSY_LAST = 8'(SM_DELAY - 2);

    // one data word
    typedef logic [SM_DATA_W-1:0] sm_word_t;

    // one byte address
    typedef logic [SM_ADDR_W-1:0] sm_addr_t;

    // delay controller states
    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,  // waiting for request, ready high
        S_BUSY  = 2'd1,  // counting, ready low
        S_READY = 2'd2   // response cycle, ready high
    } sm_delay_state_e;

endpackage

`default_nettype wire

/* rtl/sm_req_buffer.sv */
////////////////////////////////////////
// request buffer
// captures address, write enable and
// write data on start and holds them
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sm_req_buffer (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  start,   // load enable from delay controller
    input  wire sm_mem_pkg::sm_addr_t a,
    input  wire                  we,
    input  wire sm_mem_pkg::sm_word_t wd,
    output sm_mem_pkg::sm_addr_t ram_a,
    output logic                 ram_we,
    output sm_mem_pkg::sm_word_t ram_wd
);

    // address register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ram_a <= '0;
        end else if (start) begin
            ram_a <= a;
        end
    end

    // write enable register
    // cleared on reset so the array sees no stray write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ram_we <= 1'b0;
        end else if (start) begin
            ram_we <= we;
        end
    end

    // write data register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ram_wd <= '0;
        end else if (start) begin
            ram_wd <= wd;
        end
    end

    // request in flight must not move while the requester changes its inputs
    a_hold_without_start : assert property (
        @(posedge clk) disable iff (!arst_n)
        !start |=> $stable({ram_a, ram_we, ram_wd})
    ) else $error("request buffer changed without start");

endmodule

`default_nettype wire

/* rtl/sm_delay.sv */
////////////////////////////////////////
// delay controller
// accepts a request, counts the busy
// cycles and raises ready for one
// response cycle
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sm_delay (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  valid,   // read/write request
    output logic ready,   // idle or response cycle
    output logic start    // request accepted strobe
);

    import sm_mem_pkg::*;

    sm_delay_state_e state;
    sm_delay_state_e state_next;

    logic [7:0] busy_cnt;   // cycles spent in S_BUSY so far
    logic       busy_done;

    // elaboration check on the delay setting
    if (SM_DELAY < 2 || SM_DELAY > 255) begin : g_delay_range
        $error("SM_DELAY must be within 2 to 255");
    end

    assign busy_done = (busy_cnt == SM_BUSY_LAST);

    // state register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // busy counter, only runs in S_BUSY
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_cnt <= 8'd0;
        end else if (state == S_BUSY) begin
            busy_cnt <= busy_cnt + 8'd1;
        end else begin
            busy_cnt <= 8'd0;
        end
    end

    // next state
    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (valid) begin
                    state_next = S_BUSY;
                end
            end
            S_BUSY: begin
                if (busy_done) begin
                    state_next = S_READY;
                end
            end
            S_READY: state_next = S_IDLE;   // valid ignored here
            default: state_next = S_IDLE;
        endcase
    end

    // outputs
    assign ready = (state == S_IDLE) || (state == S_READY);
    assign start = valid && (state == S_IDLE);

    a_busy_not_ready : assert property (
        @(posedge clk) disable iff (!arst_n)
        (state == S_BUSY) |-> !ready
    ) else $error("ready high while busy");

    a_start_only_idle : assert property (
        @(posedge clk) disable iff (!arst_n)
        start |-> (state == S_IDLE)
    ) else $error("start outside S_IDLE");

    a_ready_one_cycle : assert property (
        @(posedge clk) disable iff (!arst_n)
        (state == S_READY) |=> (state == S_IDLE)
    ) else $error("S_READY lasted more than one cycle");

    // full request to response timing
    a_accept_timing : assert property (
        @(posedge clk) disable iff (!arst_n)
        start |=> !ready [*SM_DELAY-1] ##1 (ready && state == S_READY)
    ) else $error("response not SM_DELAY cycles after acceptance");

endmodule

`default_nettype wire

/* rtl/sm_ram.sv */
////////////////////////////////////////
// word array
// clocked write, combinational read and
// the read-data gate for the response
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sm_ram (
    input  wire                  clk,
    input  wire sm_mem_pkg::sm_addr_t a,    // buffered byte address
    input  wire                  we,
    input  wire sm_mem_pkg::sm_word_t wd,
    input  wire                  ready,     // response cycle from controller
    output sm_mem_pkg::sm_word_t rd
);

    import sm_mem_pkg::*;

    sm_word_t                 mem [SM_RAM_SIZE];
    logic [SM_WORD_IDX_W-1:0] idx;
    sm_word_t                 mem_rd;

    // word index, upper address bits wrap
    assign idx = a[SM_WORD_IDX_W+1:2];

    // write port
    // rewrites the same word every edge while we holds, harmless
    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wd;
        end
    end

    assign mem_rd = mem[idx];   // combinational read

    // read data gate
    // unknown outside a read response so a late sample shows up in simulation,
    // synthesis treats the x as don't care
    assign rd = (ready && !we) ? mem_rd : 'x;

    // a write to an unknown address would smear the whole array
    a_known_write_addr : assert property (
        @(posedge clk)
        we |-> !$isunknown(a)
    ) else $error("write with unknown address");

endmodule

`default_nettype wire

/* rtl/sm_ram_busy.sv */
////////////////////////////////////////
// busy data memory top
// request buffer, delay controller and
// word array behind a valid/ready port
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sm_ram_busy (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire sm_mem_pkg::sm_addr_t a,      // byte address
    input  wire                  we,         // write enable
    input  wire sm_mem_pkg::sm_word_t wd,     // write data
    input  wire                  valid,      // read/write request
    output wire                  ready,      // read/write done
    output sm_mem_pkg::sm_word_t rd          // read data
);

    import sm_mem_pkg::*;

    logic     start;    // accept strobe, buffer load
    sm_addr_t ram_a;
    logic     ram_we;
    sm_word_t ram_wd;

    // stage 1, request capture
    sm_req_buffer u_req_buffer (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .start  ( start  ),
        .a      ( a      ),
        .we     ( we     ),
        .wd     ( wd     ),
        .ram_a  ( ram_a  ),
        .ram_we ( ram_we ),
        .ram_wd ( ram_wd )
    );

    // stage 2, valid to ready delay
    sm_delay u_delay (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .valid  ( valid  ),
        .ready  ( ready  ),
        .start  ( start  )
    );

    // stages 3 and 4, array and read gate
    sm_ram u_ram (
        .clk    ( clk    ),
        .a      ( ram_a  ),
        .we     ( ram_we ),
        .wd     ( ram_wd ),
        .ready  ( ready  ),
        .rd     ( rd     )
    );

endmodule

`default_nettype wire

/* test/sm_ram_busy_checks.svh */
////////////////////////////////////////
// busy memory reference model
// word array model and typed compare
// tasks for the testbench
////////////////////////////////////////

`ifndef SM_RAM_BUSY_CHECKS_SVH
`define SM_RAM_BUSY_CHECKS_SVH

// model of the word array, unknown until written
sm_word_t ref_mem     [SM_RAM_SIZE];
bit       ref_written [SM_RAM_SIZE];

int unsigned n_checks    = 0;
int unsigned bit_errs    = 0;   // ready mismatches
int unsigned word_errs   = 0;   // read data mismatches
int unsigned n_unchecked = 0;   // reads of never written words

// word index of a byte address, bits 7 to 2, upper bits alias
function automatic int unsigned word_index(input sm_addr_t addr);
    return int'(addr[7:2]);
endfunction

task automatic clear_model();
    for (int i = 0; i < SM_RAM_SIZE; i++) begin
        ref_mem[i]     = 'x;
        ref_written[i] = 1'b0;
    end
endtask

task automatic store_word(input sm_addr_t addr, input sm_word_t data);
    ref_mem[word_index(addr)]     = data;
    ref_written[word_index(addr)] = 1'b1;
endtask

function automatic bit is_written(input sm_addr_t addr);
    return ref_written[word_index(addr)];
endfunction

function automatic sm_word_t expected_word(input sm_addr_t addr);
    return ref_mem[word_index(addr)];
endfunction

// one data word against the model
task automatic check_word(input string name, input sm_word_t exp, input sm_word_t act);
    n_checks++;
    if (act !== exp) begin
        word_errs++;
        $display("[ERROR] %0t: %s expected %h, got %h", $time, name, exp, act);
    end
endtask

// handshake bit
task automatic check_bit(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
        bit_errs++;
        $display("[ERROR] %0t: %s expected %b, got %b", $time, name, exp, act);
    end
endtask

`endif

/* test/sm_ram_busy_tb.sv */
////////////////////////////////////////
// busy data memory testbench
// random reads and writes with gaps and
// junk inputs while busy, model checked
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sm_ram_busy_tb;

    import sm_mem_pkg::*;

    localparam int          CLK_PERIOD   = 10;
    localparam int          DRIVE_DLY    = 1;    // ns after the rising edge
    localparam int          RESET_CYCLES = 10;
    localparam int          N_REQ        = 300;
    localparam int unsigned SEED         = 32'h9f8c_fd09;

    // worst request is 3 gap cycles, the issue cycle and SM_DELAY more
    localparam int WATCHDOG_CYCLES = (N_REQ + SM_RAM_SIZE) * (SM_DELAY + 5)
                                     + RESET_CYCLES + 20;
    localparam int WATCHDOG_NS     = WATCHDOG_CYCLES * CLK_PERIOD;

    logic     clk;
    logic     arst_n;
    sm_addr_t a;
    logic     we;
    sm_word_t wd;
    logic     valid;
    wire      ready;
    sm_word_t rd;

    `include "sm_ram_busy_checks.svh"

    sm_ram_busy u_sm_ram_busy (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .a      ( a      ),
        .we     ( we     ),
        .wd     ( wd     ),
        .valid  ( valid  ),
        .ready  ( ready  ),
        .rd     ( rd     )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // request inputs get noise, the DUT must not care
    task automatic scramble_inputs();
        a  = $urandom();
        we = 1'($urandom());
        wd = $urandom();
    endtask

    // one cycle with valid low, controller stays idle
    task automatic idle_cycle();
        @(posedge clk);
        #DRIVE_DLY;
        valid = 1'b0;
        scramble_inputs();
        @(negedge clk);
        check_bit("ready", 1'b1, ready);
    endtask

    // issue one request and follow it to its response cycle
    task automatic run_request(input sm_addr_t addr, input logic wr, input sm_word_t data);
        @(posedge clk);
        #DRIVE_DLY;
        valid = 1'b1;
        a     = addr;
        we    = wr;
        wd    = data;
        @(negedge clk);
        check_bit("ready", 1'b1, ready);   // idle, accepted at the next edge

        // busy, valid and request inputs random
        repeat (SM_DELAY - 1) begin
            @(posedge clk);
            #DRIVE_DLY;
            valid = 1'($urandom());
            scramble_inputs();
            @(negedge clk);
            check_bit("ready", 1'b0, ready);
        end

        // response cycle
        @(posedge clk);
        #DRIVE_DLY;
        valid = 1'b0;
        scramble_inputs();
        @(negedge clk);
        check_bit("ready", 1'b1, ready);
        if (wr) begin
            store_word(addr, data);
        end else if (is_written(addr)) begin
            check_word("rd", expected_word(addr), rd);
        end else begin
            n_unchecked++;
        end
    endtask

    initial begin
        int unsigned gap;
        sm_addr_t    addr;
        logic        wr;
        sm_word_t    data;

        clk    = 1'b0;
        arst_n = 1'b0;
        valid  = 1'b0;
        a      = '0;
        we     = 1'b0;
        wd     = '0;
        void'($urandom(SEED));
        clear_model();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;

        // quiet after reset, ready high throughout
        repeat (4) idle_cycle();

        for (int n = 0; n < N_REQ; n++) begin
            gap  = $urandom_range(0, 3);
            addr = $urandom() & 32'hffff_fffc;   // word aligned, high bits alias
            wr   = 1'($urandom());
            data = $urandom();
            repeat (gap) idle_cycle();
            run_request(addr, wr, data);
        end

        // back to back read sweep over every word index
        for (int i = 0; i < SM_RAM_SIZE; i++) begin
            addr = ($urandom() & 32'hffff_ff00) | (32'(i) << 2);
            run_request(addr, 1'b0, $urandom());
        end

        $display("summary: %0d checks, %0d ready errors, %0d read data errors, %0d reads unchecked",
                 n_checks, bit_errs, word_errs, n_unchecked);
        if (bit_errs + word_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d cycles, the request sequence hung", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+test
rtl/sm_mem_pkg.sv
rtl/sm_req_buffer.sv
rtl/sm_delay.sv
rtl/sm_ram.sv
rtl/sm_ram_busy.sv
test/sm_ram_busy_tb.sv

/* Bender.yml */
package:
  name: sm_ram_busy

sources:
  # design, in compile order
  - rtl/sm_mem_pkg.sv
  - rtl/sm_req_buffer.sv
  - rtl/sm_delay.sv
  - rtl/sm_ram.sv
  - rtl/sm_ram_busy.sv

  # testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/sm_ram_busy_tb.sv
